// ==== design/pipeline_pkg.sv ====
package pipeline_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] data_t;           // Register value
	typedef logic [4:0]  reg_idx_t;        // Register index
	typedef logic [31:0] inst_t;           // Instruction word
	typedef logic [11:0] imm_t;            // Zero-extended on use

	typedef logic [2:0]  buf_count_t;      // Buffer occupancy, 0 to 4
	typedef logic [1:0]  credit_count_t;   // Commit credits, 0 to 2

	// Opcode field, codes 9 to 15 are illegal
	typedef enum logic [3:0]
	{
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_AND  = 4'h2,
		ALU_OR   = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_SLL  = 4'h5,   // Shift by low 5 bits of b
		ALU_SRL  = 4'h6,   // Logical right shift
		ALU_SLT  = 4'h7,   // Signed compare, 1 or 0
		OP_HALT  = 4'h8
	} alu_op_t;

	// Commit status
	typedef enum logic [1:0]
	{
		ST_NO_ERROR          = 2'd0,
		ST_HALTED_ON_HALT    = 2'd1,
		ST_HALTED_ON_ILLEGAL = 2'd2
	} status_t;

	////////////////////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////////////////////

	localparam int OPC_HI      = 31;
	localparam int OPC_LO      = 28;
	localparam int DEST_HI     = 27;
	localparam int DEST_LO     = 23;
	localparam int RA_HI       = 22;
	localparam int RA_LO       = 18;
	localparam int RB_HI       = 17;
	localparam int RB_LO       = 13;
	localparam int IMM_SEL_BIT = 12;   // 1 selects immediate for b
	localparam int IMM_HI      = 11;
	localparam int IMM_LO      = 0;

	localparam reg_idx_t ZERO_REG = 5'd0;   // Reads zero, drops writes

	// Credit loops
	localparam int INST_CREDITS   = 4;   // Buffer depth
	localparam int COMMIT_CREDITS = 2;
	localparam int BUF_PTR_W      = $clog2(INST_CREDITS);

	typedef logic [BUF_PTR_W-1:0] buf_ptr_t;

endpackage

// ==== design/inst_buffer.sv ====
module inst_buffer
	import pipeline_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  inst_valid,    // Producer holds a credit for this one
	input  inst_t inst,
	input  logic  advance,
	output logic  head_valid,
	output inst_t head_inst,
	output logic  inst_credit    // One pulse per popped entry
);

	inst_t      mem [INST_CREDITS];   // Queue storage
	buf_ptr_t   rd_ptr;
	buf_ptr_t   wr_ptr;
	buf_count_t count;
	logic       pop;

	assign head_valid = (count != '0);
	assign head_inst  = mem[rd_ptr];
	assign pop        = advance & head_valid;   // Decode takes the head

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	// Write on arrival, head shows up next cycle
	always_ff @(posedge clock)
	begin
		if (inst_valid)
			mem[wr_ptr] <= inst;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (inst_valid)
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave count as is
			count <= count + buf_count_t'(inst_valid) - buf_count_t'(pop);
		end
	end

	// Credit back to producer
	always_ff @(posedge clock)
	begin
		if (reset)
			inst_credit <= 1'b0;
		else
			inst_credit <= pop;   // One cycle after the pop
	end

endmodule

// ==== design/reg_file.sv ====
module reg_file
	import pipeline_pkg::*;
(
	input  logic     clock,
	input  reg_idx_t ra_idx,
	input  reg_idx_t rb_idx,
	output data_t    ra_data,
	output data_t    rb_data,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  data_t    wr_data
);

	data_t regs [2**$bits(reg_idx_t)];   // No reset on the array

	// Read port A
	always_comb
	begin
		if (ra_idx == ZERO_REG)
			ra_data = '0;
		else if (wr_en && (wr_idx == ra_idx))
			ra_data = wr_data;   // Write-through
		else
			ra_data = regs[ra_idx];
	end

	// Read port B, same rules
	always_comb
	begin
		if (rb_idx == ZERO_REG)
			rb_data = '0;
		else if (wr_en && (wr_idx == rb_idx))
			rb_data = wr_data;
		else
			rb_data = regs[rb_idx];
	end

	always_ff @(posedge clock)
	begin
		if (wr_en && (wr_idx != ZERO_REG))   // Zero register stays zero
			regs[wr_idx] <= wr_data;
	end

endmodule

// ==== design/decode_stage.sv ====
module decode_stage
	import pipeline_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     advance,
	input  logic     head_valid,
	input  inst_t    head_inst,
	input  logic     wr_en,       // Writeback port into the register file
	input  reg_idx_t wr_idx,
	input  data_t    wr_data,
	output logic     dx_valid,
	output alu_op_t  dx_op,
	output reg_idx_t dx_dest,
	output reg_idx_t dx_ra_idx,
	output reg_idx_t dx_rb_idx,
	output data_t    dx_a,
	output data_t    dx_b,
	output logic     dx_imm_sel,
	output imm_t     dx_imm
);

	alu_op_t  op;
	reg_idx_t dest;
	reg_idx_t ra_idx;
	reg_idx_t rb_idx;
	logic     imm_sel;
	imm_t     imm;
	data_t    ra_data;
	data_t    rb_data;
	logic     stops;     // Halt or illegal code
	logic     halted;    // Sticky until reset

	////////////////////////////////////////////////////////////////////////////
	// Field split
	////////////////////////////////////////////////////////////////////////////

	assign op      = alu_op_t'(head_inst[OPC_HI:OPC_LO]);   // May hold an illegal code
	assign dest    = head_inst[DEST_HI:DEST_LO];
	assign ra_idx  = head_inst[RA_HI:RA_LO];
	assign rb_idx  = head_inst[RB_HI:RB_LO];
	assign imm_sel = head_inst[IMM_SEL_BIT];
	assign imm     = head_inst[IMM_HI:IMM_LO];

	// Anything past the ALU codes ends the stream
	assign stops = (head_inst[OPC_HI:OPC_LO] > 4'(ALU_SLT));

	reg_file reg_file_i
	(
		.clock   (clock),
		.ra_idx  (ra_idx),
		.rb_idx  (rb_idx),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			dx_valid <= 1'b0;
			halted   <= 1'b0;
		end
		else if (advance)
		begin
			dx_valid <= head_valid & ~halted;   // Bubbles once halted
			if (head_valid && !halted && stops)
				halted <= 1'b1;
		end
	end

	// Payload, meaningless when dx_valid is low
	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			dx_op      <= op;
			dx_dest    <= dest;
			dx_ra_idx  <= ra_idx;
			dx_rb_idx  <= rb_idx;
			dx_a       <= ra_data;
			dx_b       <= rb_data;
			dx_imm_sel <= imm_sel;
			dx_imm     <= imm;
		end
	end

endmodule

// ==== design/execute_stage.sv ====
module execute_stage
	import pipeline_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     advance,
	input  logic     dx_valid,
	input  alu_op_t  dx_op,
	input  reg_idx_t dx_dest,
	input  reg_idx_t dx_ra_idx,
	input  reg_idx_t dx_rb_idx,
	input  data_t    dx_a,
	input  data_t    dx_b,
	input  logic     dx_imm_sel,
	input  imm_t     dx_imm,
	input  logic     wr_en,       // Write port seen for forwarding
	input  reg_idx_t wr_idx,
	input  data_t    wr_data,
	output logic     xw_valid,
	output logic     xw_wr_en,
	output reg_idx_t xw_dest,
	output data_t    xw_result,
	output status_t  xw_status
);

	data_t   fwd_a;
	data_t   fwd_b;
	data_t   opnd_b;
	data_t   result;
	logic    is_alu;
	status_t status;

	// Writeback result beats the stale ID/EX value
	assign fwd_a = (wr_en && (wr_idx != ZERO_REG) && (wr_idx == dx_ra_idx)) ? wr_data : dx_a;
	assign fwd_b = (wr_en && (wr_idx != ZERO_REG) && (wr_idx == dx_rb_idx)) ? wr_data : dx_b;

	assign opnd_b = dx_imm_sel ? data_t'(dx_imm) : fwd_b;   // Zero-extended

	////////////////////////////////////////////////////////////////////////////
	// ALU and status
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		is_alu = 1'b1;
		status = ST_NO_ERROR;
		result = '0;
		case (dx_op)
			ALU_ADD: result = fwd_a + opnd_b;
			ALU_SUB: result = fwd_a - opnd_b;
			ALU_AND: result = fwd_a & opnd_b;
			ALU_OR:  result = fwd_a | opnd_b;
			ALU_XOR: result = fwd_a ^ opnd_b;
			ALU_SLL: result = fwd_a << opnd_b[4:0];
			ALU_SRL: result = fwd_a >> opnd_b[4:0];
			ALU_SLT: result = data_t'($signed(fwd_a) < $signed(opnd_b));
			OP_HALT:
			begin
				is_alu = 1'b0;
				status = ST_HALTED_ON_HALT;
			end
			default:
			begin
				is_alu = 1'b0;   // Unknown code
				status = ST_HALTED_ON_ILLEGAL;
			end
		endcase
	end

	// EX/WB register
	always_ff @(posedge clock)
	begin
		if (reset)
			xw_valid <= 1'b0;
		else if (advance)
			xw_valid <= dx_valid;
	end

	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			xw_wr_en  <= is_alu & (dx_dest != ZERO_REG);
			xw_dest   <= dx_dest;
			xw_result <= result;
			xw_status <= status;
		end
	end

endmodule

// ==== design/writeback_stage.sv ====
module writeback_stage
	import pipeline_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     xw_valid,
	input  logic     xw_wr_en,
	input  reg_idx_t xw_dest,
	input  data_t    xw_result,
	input  status_t  xw_status,
	input  logic     commit_credit,   // One credit back per pulse
	output logic     advance,
	output logic     wr_en,
	output reg_idx_t wr_idx,
	output data_t    wr_data,
	output logic     commit_valid,
	output logic     commit_wr_en,
	output reg_idx_t commit_idx,
	output data_t    commit_data,
	output status_t  commit_status
);

	credit_count_t credits;     // Commits the consumer can still take
	logic          no_credit;

	assign no_credit = (credits == '0);

	////////////////////////////////////////////////////////////////////////////
	// Commit and stall
	////////////////////////////////////////////////////////////////////////////

	// Fires in the same cycle the instruction sits in EX/WB
	assign commit_valid = xw_valid & ~no_credit;

	// Whole pipeline freezes on a stuck commit
	assign advance = ~(xw_valid & no_credit);

	assign commit_wr_en  = commit_valid & xw_wr_en;
	assign commit_idx    = xw_dest;
	assign commit_data   = xw_result;
	assign commit_status = xw_status;

	// Register file write, only for a commit that fires
	assign wr_en   = commit_valid & xw_wr_en;
	assign wr_idx  = xw_dest;
	assign wr_data = xw_result;

	////////////////////////////////////////////////////////////////////////////
	// Credit counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			credits <= credit_count_t'(COMMIT_CREDITS);   // Full after reset
		else
			// Return and spend in one cycle cancel
			credits <= credits + credit_count_t'(commit_credit)
				- credit_count_t'(commit_valid);
	end

endmodule

// ==== design/pipeline.sv ====
module pipeline
	import pipeline_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     inst_valid,
	input  inst_t    inst,
	output logic     inst_credit,
	output logic     commit_valid,
	output logic     commit_wr_en,
	output reg_idx_t commit_idx,
	output data_t    commit_data,
	output status_t  commit_status,
	input  logic     commit_credit
);

	logic     advance;      // Global stage enable
	logic     head_valid;
	inst_t    head_inst;

	// ID/EX
	logic     dx_valid;
	alu_op_t  dx_op;
	reg_idx_t dx_dest;
	reg_idx_t dx_ra_idx;
	reg_idx_t dx_rb_idx;
	data_t    dx_a;
	data_t    dx_b;
	logic     dx_imm_sel;
	imm_t     dx_imm;

	// EX/WB
	logic     xw_valid;
	logic     xw_wr_en;
	reg_idx_t xw_dest;
	data_t    xw_result;
	status_t  xw_status;

	// Register write, also the forward path
	logic     wr_en;
	reg_idx_t wr_idx;
	data_t    wr_data;

	////////////////////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////////////////////

	inst_buffer buffer_i
	(
		.clock       (clock),
		.reset       (reset),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.advance     (advance),
		.head_valid  (head_valid),
		.head_inst   (head_inst),
		.inst_credit (inst_credit)
	);

	////////////////////////////////////////////////////////////////////////////
	// Decode and execute
	////////////////////////////////////////////////////////////////////////////

	decode_stage decode_i
	(
		.clock      (clock),
		.reset      (reset),
		.advance    (advance),
		.head_valid (head_valid),
		.head_inst  (head_inst),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_data    (wr_data),
		.dx_valid   (dx_valid),
		.dx_op      (dx_op),
		.dx_dest    (dx_dest),
		.dx_ra_idx  (dx_ra_idx),
		.dx_rb_idx  (dx_rb_idx),
		.dx_a       (dx_a),
		.dx_b       (dx_b),
		.dx_imm_sel (dx_imm_sel),
		.dx_imm     (dx_imm)
	);

	execute_stage execute_i
	(
		.clock      (clock),
		.reset      (reset),
		.advance    (advance),
		.dx_valid   (dx_valid),
		.dx_op      (dx_op),
		.dx_dest    (dx_dest),
		.dx_ra_idx  (dx_ra_idx),
		.dx_rb_idx  (dx_rb_idx),
		.dx_a       (dx_a),
		.dx_b       (dx_b),
		.dx_imm_sel (dx_imm_sel),
		.dx_imm     (dx_imm),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_data    (wr_data),
		.xw_valid   (xw_valid),
		.xw_wr_en   (xw_wr_en),
		.xw_dest    (xw_dest),
		.xw_result  (xw_result),
		.xw_status  (xw_status)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output side
	////////////////////////////////////////////////////////////////////////////

	writeback_stage writeback_i
	(
		.clock         (clock),
		.reset         (reset),
		.xw_valid      (xw_valid),
		.xw_wr_en      (xw_wr_en),
		.xw_dest       (xw_dest),
		.xw_result     (xw_result),
		.xw_status     (xw_status),
		.commit_credit (commit_credit),
		.advance       (advance),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_data       (wr_data),
		.commit_valid  (commit_valid),
		.commit_wr_en  (commit_wr_en),
		.commit_idx    (commit_idx),
		.commit_data   (commit_data),
		.commit_status (commit_status)
	);

endmodule

// ==== sim/pipeline_chk.sv ====
module pipeline_chk
	import pipeline_pkg::*;
(
	input logic          clock,
	input logic          reset,
	input logic          commit_valid,
	input logic          commit_credit,   // Consumer pays back here
	input credit_count_t credits,         // Writeback credit counter
	input buf_count_t    count            // Buffer occupancy
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned failures = 0;   // Read by the testbench summary
	int unsigned commits_seen;   // Commits since reset
	int unsigned returns_seen;   // Credit pulses since reset

	////////////////////////////////////////////////////////////////////////////
	// Credit loops
	////////////////////////////////////////////////////////////////////////////

	// Port-level tally, kept apart from the writeback counter
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			commits_seen <= 0;
			returns_seen <= 0;
		end
		else
		begin
			if (commit_valid)
				commits_seen <= commits_seen + 1;
			if (commit_credit)
				returns_seen <= returns_seen + 1;
		end
	end

	// A commit needs a credit in hand, initial ones plus those paid back
	commit_has_credit: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> (commits_seen < returns_seen + COMMIT_CREDITS))
	else
	begin
		failures++;
		$error("commit_valid high with zero commit credits");
	end

	commit_credit_bound: assert property (@(posedge clock) disable iff (reset)
		credits <= credit_count_t'(COMMIT_CREDITS))
	else
	begin
		failures++;
		$error("commit credit count above its initial value");
	end

	// Producer credits keep the queue from overflowing
	buffer_bound: assert property (@(posedge clock) disable iff (reset)
		count <= buf_count_t'(INST_CREDITS))
	else
	begin
		failures++;
		$error("instruction buffer holds more entries than its depth");
	end

endmodule

bind pipeline pipeline_chk chk_i
(
	.clock         (clock),
	.reset         (reset),
	.commit_valid  (commit_valid),
	.commit_credit (commit_credit),
	.credits       (writeback_i.credits),
	.count         (buffer_i.count)
);

// ==== sim/pipeline_tb.sv ====
module pipeline_tb
	import pipeline_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;

	// Test lengths in instructions
	localparam int N_INIT    = 31;
	localparam int N_RANDOM  = 200;
	localparam int N_CHAIN   = 120;
	localparam int N_ZERO    = 40;
	localparam int N_STALL   = 150;
	localparam int N_HALT    = 16;
	localparam int N_ILLEGAL = 16;
	localparam int TOTAL_INST = N_INIT + N_RANDOM + N_CHAIN + N_ZERO + N_STALL
		+ N_HALT + N_ILLEGAL;
	localparam int WATCHDOG_CYCLES = 20 * TOTAL_INST + 3 * RESET_CYCLES;   // Three resets

	// Stimulus kinds
	localparam int K_INIT    = 0;
	localparam int K_RANDOM  = 1;
	localparam int K_CHAIN   = 2;
	localparam int K_ZERO    = 3;
	localparam int K_HALT    = 4;
	localparam int K_ILLEGAL = 5;

	logic     clock = 1'b0;
	logic     reset = 1'b1;
	logic     inst_valid;
	inst_t    inst;
	logic     inst_credit;
	logic     commit_valid;
	logic     commit_wr_en;
	reg_idx_t commit_idx;
	data_t    commit_data;
	status_t  commit_status;
	logic     commit_credit;

	logic [31:0] lcg_state;
	string       cur_test;
	int          errors = 0;
	int          checks = 0;
	int          tests  = 0;
	int          prod_credits;     // Producer's instruction credits
	int          tb_credits;       // Commit credits the DUT should hold
	int          pending;          // Commits not yet paid back
	int          sent;
	logic        model_halted;
	reg_idx_t    last_dest;
	data_t       model_regs [32];  // Architectural registers

	// Expected commits, oldest first
	reg_idx_t exp_idx    [$];
	data_t    exp_data   [$];
	logic     exp_wr     [$];
	status_t  exp_status [$];

	always #(CLK_PERIOD / 2) clock = ~clock;

	pipeline dut_i
	(
		.clock         (clock),
		.reset         (reset),
		.inst_valid    (inst_valid),
		.inst          (inst),
		.inst_credit   (inst_credit),
		.commit_valid  (commit_valid),
		.commit_wr_en  (commit_wr_en),
		.commit_idx    (commit_idx),
		.commit_data   (commit_data),
		.commit_status (commit_status),
		.commit_credit (commit_credit)
	);

	////////////////////////////////////////////////////////////////////////////
	// Random numbers and the reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_pct();
		return int'((next_rand() >> 16) % 100);   // Upper bits, low ones cycle fast
	endfunction

	function automatic inst_t make_inst(input logic [3:0] op, input reg_idx_t dest,
		input reg_idx_t ra, input reg_idx_t rb, input logic sel, input imm_t imm);
		inst_t w;
		w = '0;
		w[OPC_HI:OPC_LO]   = op;
		w[DEST_HI:DEST_LO] = dest;
		w[RA_HI:RA_LO]     = ra;
		w[RB_HI:RB_LO]     = rb;
		w[IMM_SEL_BIT]     = sel;
		w[IMM_HI:IMM_LO]   = imm;
		return w;
	endfunction

	// Opcode rules as given for the ALU
	function automatic data_t model_alu(input logic [3:0] op, input data_t a, input data_t b);
		case (alu_op_t'(op))
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[4:0];
			ALU_SRL: return a >> b[4:0];
			ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	function automatic inst_t gen_inst(input int kind, input int i, input int n);
		logic [31:0] r;
		logic [31:0] s;
		logic [3:0]  op;
		reg_idx_t    dest;
		reg_idx_t    ra;
		reg_idx_t    rb;
		logic        sel;
		imm_t        imm;
		r    = next_rand();
		s    = next_rand();
		op   = {1'b0, r[30:28]};   // Any ALU code
		dest = r[27:23];
		ra   = r[22:18];
		rb   = r[17:13];
		sel  = r[12];
		imm  = s[27:16];
		case (kind)
			K_INIT:
			begin
				op   = ALU_ADD;   // r[i+1] = 0 + imm
				dest = 5'(i + 1);
				ra   = ZERO_REG;
				sel  = 1'b1;
			end
			K_CHAIN:
			begin
				if (dest == ZERO_REG)
					dest = 5'd1;
				ra = last_dest;   // Reads the previous result
				if (s[0])
					rb = last_dest;
				sel       = (s[2:1] == 2'b00);
				last_dest = dest;
			end
			K_ZERO:
			begin
				if (i % 2 == 0)
					dest = ZERO_REG;   // Dropped write
				else
				begin
					ra = ZERO_REG;
					if (s[0])
						rb = ZERO_REG;
				end
			end
			K_HALT:
				if (i == n / 2)
					op = OP_HALT;
			K_ILLEGAL:
			begin
				if (i == n / 2)
					op = (s[2:0] == 3'd0) ? 4'hf : {1'b1, s[2:0]};   // 9 to 15
			end
			default: ;
		endcase
		return make_inst(op, dest, ra, rb, sel, imm);
	endfunction

	// In-order architectural effect of one sent instruction
	task automatic model_apply(input inst_t w);
		logic [3:0] op;
		reg_idx_t   dest;
		data_t      a;
		data_t      b;
		data_t      res;
		op   = w[OPC_HI:OPC_LO];
		dest = w[DEST_HI:DEST_LO];
		if (model_halted)
			return;   // Discarded after a stop
		if (op > 4'(ALU_SLT))
		begin
			model_halted = 1'b1;
			exp_idx.push_back(dest);
			exp_data.push_back('0);
			exp_wr.push_back(1'b0);
			exp_status.push_back((op == 4'(OP_HALT)) ? ST_HALTED_ON_HALT : ST_HALTED_ON_ILLEGAL);
			return;
		end
		a   = model_regs[w[RA_HI:RA_LO]];
		b   = w[IMM_SEL_BIT] ? data_t'(w[IMM_HI:IMM_LO]) : model_regs[w[RB_HI:RB_LO]];
		res = model_alu(op, a, b);
		if (dest != ZERO_REG)
			model_regs[dest] = res;   // r0 stays zero
		exp_idx.push_back(dest);
		exp_data.push_back(res);
		exp_wr.push_back(dest != ZERO_REG);
		exp_status.push_back(ST_NO_ERROR);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_data(input string what, input data_t exp, input data_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_idx(input string what, input reg_idx_t exp, input reg_idx_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_status(input string what, input status_t exp, input status_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s %s: expected %s, actual %s", cur_test, what, exp.name(),
				act.name());
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%s: %s", cur_test, msg);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per-cycle sampling and driving
	////////////////////////////////////////////////////////////////////////////

	// Outputs are settled at the falling edge
	task automatic sample_outputs();
		status_t st;
		if (inst_credit)
		begin
			if (prod_credits >= INST_CREDITS)
				report_failure("instruction credit returned with none outstanding");
			else
				prod_credits++;
		end
		if (commit_valid)
		begin
			if (tb_credits == 0)
				report_failure("commit fired while the pipeline held no commit credit");
			else
				tb_credits--;
			pending++;
			if (exp_idx.size() == 0)
				report_failure("commit arrived with no instruction outstanding");
			else
			begin
				st = exp_status.pop_front();
				check_status("commit_status", st, commit_status);
				check_idx("commit_idx", exp_idx.pop_front(), commit_idx);
				check_flag("commit_wr_en", exp_wr.pop_front(), commit_wr_en);
				if (st == ST_NO_ERROR)
					check_data("commit_data", exp_data.pop_front(), commit_data);
				else
					void'(exp_data.pop_front());   // Stop carries no result
			end
		end
	endtask

	// Consumer pays back commits at a given rate
	task automatic drive_consumer(input int return_pct);
		if (pending > 0 && rand_pct() < return_pct)
		begin
			commit_credit = 1'b1;
			pending--;
			tb_credits++;
		end
		else
			commit_credit = 1'b0;
	endtask

	task automatic do_reset();
		reset         = 1'b1;
		inst_valid    = 1'b0;
		commit_credit = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset        = 1'b0;
		prod_credits = INST_CREDITS;
		tb_credits   = COMMIT_CREDITS;
		pending      = 0;
		model_halted = 1'b0;
	endtask

	task automatic run_test(input string name, input int kind, input int n,
		input int send_pct, input int return_pct);
		int start_errors;
		start_errors = errors;
		cur_test     = name;
		sent         = 0;
		last_dest    = 5'd1;
		// Done once every commit is seen and every credit is back
		while (!(sent == n && exp_idx.size() == 0 && prod_credits == INST_CREDITS
			&& pending == 0))
		begin
			@(negedge clock);
			sample_outputs();
			drive_consumer(return_pct);
			if (sent < n && prod_credits > 0 && rand_pct() < send_pct)
			begin
				inst_valid = 1'b1;
				inst       = gen_inst(kind, sent, n);
				prod_credits--;
				sent++;
				model_apply(inst);
			end
			else
				inst_valid = 1'b0;
		end
		repeat (4)   // Idle tail catches stray commits
		begin
			@(negedge clock);
			sample_outputs();
			drive_consumer(100);
		end
		tests++;
		$display("test %-10s %4d instructions, %0d errors", name, n, errors - start_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int total;
		inst_valid    = 1'b0;
		inst          = '0;
		commit_credit = 1'b0;
		lcg_state     = 32'hd725_9755;
		foreach (model_regs[k])
			model_regs[k] = '0;
		do_reset();
		run_test("init_regs", K_INIT, N_INIT, 100, 100);   // Every register written first
		run_test("random_alu", K_RANDOM, N_RANDOM, 75, 100);
		run_test("dep_chain", K_CHAIN, N_CHAIN, 100, 100);
		run_test("zero_reg", K_ZERO, N_ZERO, 75, 100);
		run_test("stall", K_RANDOM, N_STALL, 90, 25);   // Credits held back
		do_reset();
		run_test("halt", K_HALT, N_HALT, 100, 60);
		do_reset();   // Register file keeps its contents
		run_test("illegal", K_ILLEGAL, N_ILLEGAL, 100, 60);
		total = errors + int'(dut_i.chk_i.failures);
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
			errors, dut_i.chk_i.failures);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles with a test still running",
			WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== pipeline.f ====
design/pipeline_pkg.sv
design/inst_buffer.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/pipeline.sv
sim/pipeline_chk.sv
sim/pipeline_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipeline testbench

SOURCES := $(filter-out +%,$(shell cat pipeline.f))

obj_dir/Vpipeline_tb: pipeline.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
		-f pipeline.f --top-module pipeline_tb -o Vpipeline_tb

# Pass only when the pass line shows up in the output
run: obj_dir/Vpipeline_tb
	./obj_dir/Vpipeline_tb +verilator+error+limit+1000 | tee /dev/stderr | \
		grep -x 'ALL CHECKS PASSED' > /dev/null

clean:
	rm -rf obj_dir

.PHONY: run clean
